/* rtl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_core (
    input  logic                clk,
    input  logic                rst,
    output logic [`RV_XLEN-1:0] im_addr,
    input  logic [`RV_XLEN-1:0] im_out,
    output logic                dm_read,
    output logic [3:0]          dm_wen,
    output logic [`RV_XLEN-1:0] dm_addr,
    output logic [`RV_XLEN-1:0] dm_in,
    input  logic [`RV_XLEN-1:0] dm_out
);

    logic [`RV_REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [`RV_XLEN-1:0]       rs1_data, rs2_data;

    // Decode to execute
    logic [`RV_XLEN-1:0]       ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
    logic [`RV_REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
    rv_core_pkg::alu_op_t      ex_alu_op;
    rv_core_pkg::br_cond_t     ex_br_cond;
    rv_core_pkg::mem_width_t   ex_width;
    logic                      ex_jal, ex_jalr, ex_src_a_pc, ex_src_b_imm;
    logic                      ex_mem_read, ex_mem_write, ex_reg_write;

    logic                      redirect;
    logic [`RV_XLEN-1:0]       redirect_pc;

    // Execute to memory
    logic [`RV_XLEN-1:0]       mem_addr, mem_store_data;
    logic                      mem_read, mem_write, mem_reg_write;
    rv_core_pkg::mem_width_t   mem_width;
    logic [`RV_REG_ADDR_W-1:0] mem_rd;

    logic                      wb_en;
    logic [`RV_REG_ADDR_W-1:0] wb_rd;
    logic [`RV_XLEN-1:0]       wb_data;

    rv_decode u_decode (
        .clk, .rst, .im_out, .redirect, .redirect_pc, .rs1_data, .rs2_data,
        .im_addr, .rs1_addr, .rs2_addr,
        .ex_pc, .ex_rs1, .ex_rs2, .ex_rd, .ex_imm, .ex_alu_op, .ex_br_cond,
        .ex_jal, .ex_jalr, .ex_src_a_pc, .ex_src_b_imm,
        .ex_mem_read, .ex_mem_write, .ex_width, .ex_reg_write,
        .ex_rs1_data, .ex_rs2_data
    );

    rv_regfile u_regfile (
        .clk, .rst, .rs1_addr, .rs2_addr, .wb_en, .wb_rd, .wb_data,
        .rs1_data, .rs2_data
    );

    rv_execute u_execute (
        .clk, .rst,
        .ex_pc, .ex_rs1, .ex_rs2, .ex_rd, .ex_imm, .ex_alu_op, .ex_br_cond,
        .ex_jal, .ex_jalr, .ex_src_a_pc, .ex_src_b_imm,
        .ex_mem_read, .ex_mem_write, .ex_width, .ex_reg_write,
        .ex_rs1_data, .ex_rs2_data,
        .wb_en, .wb_rd, .wb_data,
        .redirect, .redirect_pc,
        .mem_addr, .mem_store_data, .mem_read, .mem_write, .mem_width,
        .mem_rd, .mem_reg_write
    );

    rv_result u_result (
        .clk, .rst,
        .mem_addr, .mem_store_data, .mem_read, .mem_write, .mem_width,
        .mem_rd, .mem_reg_write, .dm_out,
        .dm_read, .dm_wen, .dm_addr, .dm_in,
        .wb_en, .wb_rd, .wb_data
    );

endmodule

`default_nettype wire

/* rtl/rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Datapath and register file sizes
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_REG_COUNT   32

// Fetch
`define RV_RESET_PC    32'h0000_0000
`define RV_PC_STEP     32'd4

// Decoded as a no-operation
`define RV_BUBBLE      32'h0000_0000

// Active-low byte enables, no lane written
`define RV_WEN_NONE    4'b1111

`endif

/* rtl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    // LINK yields operand A plus four
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B, ALU_LINK
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_t;

    // Same encoding as funct3 of loads and stores
    typedef enum logic [2:0] {
        MW_BYTE  = 3'b000,
        MW_HALF  = 3'b001,
        MW_WORD  = 3'b010,
        MW_UBYTE = 3'b100,
        MW_UHALF = 3'b101
    } mem_width_t;

endpackage

`default_nettype wire

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`RV_XLEN-1:0]         im_out,
    input  logic                        redirect,
    input  logic [`RV_XLEN-1:0]         redirect_pc,
    input  logic [`RV_XLEN-1:0]         rs1_data,
    input  logic [`RV_XLEN-1:0]         rs2_data,
    output logic [`RV_XLEN-1:0]         im_addr,
    output logic [`RV_REG_ADDR_W-1:0]   rs1_addr,
    output logic [`RV_REG_ADDR_W-1:0]   rs2_addr,
    output logic [`RV_XLEN-1:0]         ex_pc,
    output logic [`RV_REG_ADDR_W-1:0]   ex_rs1,
    output logic [`RV_REG_ADDR_W-1:0]   ex_rs2,
    output logic [`RV_REG_ADDR_W-1:0]   ex_rd,
    output logic [`RV_XLEN-1:0]         ex_imm,
    output rv_core_pkg::alu_op_t        ex_alu_op,
    output rv_core_pkg::br_cond_t       ex_br_cond,
    output logic                        ex_jal,
    output logic                        ex_jalr,
    output logic                        ex_src_a_pc,
    output logic                        ex_src_b_imm,
    output logic                        ex_mem_read,
    output logic                        ex_mem_write,
    output rv_core_pkg::mem_width_t     ex_width,
    output logic                        ex_reg_write,
    output logic [`RV_XLEN-1:0]         ex_rs1_data,
    output logic [`RV_XLEN-1:0]         ex_rs2_data
);

    logic [`RV_XLEN-1:0]      pc;
    logic [`RV_XLEN-1:0]      if_pc;
    logic [`RV_XLEN-1:0]      if_inst;
    rv_core_pkg::opcode_t     opcode;
    logic [2:0]               funct3;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]      imm;
    rv_core_pkg::alu_op_t     alu_op;
    rv_core_pkg::br_cond_t    br_cond;
    logic                     src_a_pc;
    logic                     src_b_imm;
    logic                     reg_write;
    logic                     load_use;
    logic                     bubble;

    assign im_addr  = pc;
    assign opcode   = rv_core_pkg::opcode_t'(if_inst[6:0]);
    assign funct3   = if_inst[14:12];
    assign rd       = if_inst[11:7];
    assign rs1_addr = if_inst[19:15];
    assign rs2_addr = if_inst[24:20];

    // Load in execute feeding the instruction in decode
    assign load_use = ex_mem_read && ex_reg_write && (ex_rd == rs1_addr || ex_rd == rs2_addr);
    assign bubble   = redirect || load_use;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc      <= `RV_RESET_PC;
            if_inst <= `RV_BUBBLE;
        end else if (redirect) begin
            pc      <= redirect_pc;
            if_inst <= `RV_BUBBLE;
        end else if (!load_use) begin
            pc      <= pc + `RV_PC_STEP;
            if_inst <= im_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!load_use) begin
            if_pc <= pc;
        end
    end

    always_comb begin
        alu_op    = rv_core_pkg::ALU_ADD;
        br_cond   = rv_core_pkg::BR_NONE;
        src_a_pc  = 1'b0;
        src_b_imm = 1'b1;
        reg_write = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_LUI: begin
                alu_op    = rv_core_pkg::ALU_PASS_B;
                reg_write = 1'b1;
            end
            rv_core_pkg::OPC_AUIPC: begin
                src_a_pc  = 1'b1;
                reg_write = 1'b1;
            end
            rv_core_pkg::OPC_JAL, rv_core_pkg::OPC_JALR: begin
                alu_op    = rv_core_pkg::ALU_LINK;
                src_a_pc  = 1'b1;
                reg_write = 1'b1;
            end
            rv_core_pkg::OPC_BRANCH: begin
                src_b_imm = 1'b0;
                case (funct3)
                    3'b000:  br_cond = rv_core_pkg::BR_EQ;
                    3'b001:  br_cond = rv_core_pkg::BR_NE;
                    3'b100:  br_cond = rv_core_pkg::BR_LT;
                    3'b101:  br_cond = rv_core_pkg::BR_GE;
                    3'b110:  br_cond = rv_core_pkg::BR_LTU;
                    3'b111:  br_cond = rv_core_pkg::BR_GEU;
                    default: br_cond = rv_core_pkg::BR_NONE;
                endcase
            end
            rv_core_pkg::OPC_OP, rv_core_pkg::OPC_OP_IMM: begin
                src_b_imm = (opcode == rv_core_pkg::OPC_OP_IMM);
                reg_write = 1'b1;
                case (funct3)
                    3'b000: begin
                        // SUB only exists in the register form
                        alu_op = (!src_b_imm && if_inst[30]) ? rv_core_pkg::ALU_SUB
                                                              : rv_core_pkg::ALU_ADD;
                    end
                    3'b001:  alu_op = rv_core_pkg::ALU_SLL;
                    3'b010:  alu_op = rv_core_pkg::ALU_SLT;
                    3'b011:  alu_op = rv_core_pkg::ALU_SLTU;
                    3'b100:  alu_op = rv_core_pkg::ALU_XOR;
                    3'b101:  alu_op = if_inst[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
                    3'b110:  alu_op = rv_core_pkg::ALU_OR;
                    default: alu_op = rv_core_pkg::ALU_AND;
                endcase
            end
            rv_core_pkg::OPC_LOAD: reg_write = 1'b1;
            default: ;
        endcase
    end

    // Immediate by instruction format
    always_comb begin
        case (opcode)
            rv_core_pkg::OPC_LUI, rv_core_pkg::OPC_AUIPC:
                imm = {if_inst[31:12], 12'b0};
            rv_core_pkg::OPC_JAL:
                imm = {{12{if_inst[31]}}, if_inst[19:12], if_inst[20], if_inst[30:21], 1'b0};
            rv_core_pkg::OPC_BRANCH:
                imm = {{20{if_inst[31]}}, if_inst[7], if_inst[30:25], if_inst[11:8], 1'b0};
            rv_core_pkg::OPC_STORE:
                imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
            default:
                imm = {{20{if_inst[31]}}, if_inst[31:20]};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_jal       <= 1'b0;
            ex_jalr      <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_br_cond   <= rv_core_pkg::BR_NONE;
        end else begin
            ex_jal       <= !bubble && opcode == rv_core_pkg::OPC_JAL;
            ex_jalr      <= !bubble && opcode == rv_core_pkg::OPC_JALR;
            ex_mem_read  <= !bubble && opcode == rv_core_pkg::OPC_LOAD;
            ex_mem_write <= !bubble && opcode == rv_core_pkg::OPC_STORE;
            ex_reg_write <= !bubble && reg_write && rd != '0;
            ex_br_cond   <= bubble ? rv_core_pkg::BR_NONE : br_cond;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= if_pc;
        ex_rs1       <= rs1_addr;
        ex_rs2       <= rs2_addr;
        ex_rd        <= rd;
        ex_imm       <= imm;
        ex_alu_op    <= alu_op;
        ex_src_a_pc  <= src_a_pc;
        ex_src_b_imm <= src_b_imm;
        ex_width     <= rv_core_pkg::mem_width_t'(funct3);
        ex_rs1_data  <= rs1_data;
        ex_rs2_data  <= rs2_data;
    end

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_execute (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`RV_XLEN-1:0]         ex_pc,
    input  logic [`RV_REG_ADDR_W-1:0]   ex_rs1,
    input  logic [`RV_REG_ADDR_W-1:0]   ex_rs2,
    input  logic [`RV_REG_ADDR_W-1:0]   ex_rd,
    input  logic [`RV_XLEN-1:0]         ex_imm,
    input  rv_core_pkg::alu_op_t        ex_alu_op,
    input  rv_core_pkg::br_cond_t       ex_br_cond,
    input  logic                        ex_jal,
    input  logic                        ex_jalr,
    input  logic                        ex_src_a_pc,
    input  logic                        ex_src_b_imm,
    input  logic                        ex_mem_read,
    input  logic                        ex_mem_write,
    input  rv_core_pkg::mem_width_t     ex_width,
    input  logic                        ex_reg_write,
    input  logic [`RV_XLEN-1:0]         ex_rs1_data,
    input  logic [`RV_XLEN-1:0]         ex_rs2_data,
    input  logic                        wb_en,
    input  logic [`RV_REG_ADDR_W-1:0]   wb_rd,
    input  logic [`RV_XLEN-1:0]         wb_data,
    output logic                        redirect,
    output logic [`RV_XLEN-1:0]         redirect_pc,
    output logic [`RV_XLEN-1:0]         mem_addr,
    output logic [`RV_XLEN-1:0]         mem_store_data,
    output logic                        mem_read,
    output logic                        mem_write,
    output rv_core_pkg::mem_width_t     mem_width,
    output logic [`RV_REG_ADDR_W-1:0]   mem_rd,
    output logic                        mem_reg_write
);

    logic [`RV_XLEN-1:0] fwd_a;
    logic [`RV_XLEN-1:0] fwd_b;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] target;
    logic                fwd_mem;
    logic                taken;

    // A load in memory has no data yet; the load-use stall covers that case
    assign fwd_mem = mem_reg_write && !mem_read;

    always_comb begin
        if (fwd_mem && mem_rd == ex_rs1) begin
            fwd_a = mem_addr;
        end else if (wb_en && wb_rd == ex_rs1) begin
            fwd_a = wb_data;
        end else begin
            fwd_a = ex_rs1_data;
        end
        if (fwd_mem && mem_rd == ex_rs2) begin
            fwd_b = mem_addr;
        end else if (wb_en && wb_rd == ex_rs2) begin
            fwd_b = wb_data;
        end else begin
            fwd_b = ex_rs2_data;
        end
    end

    assign op_a = ex_src_a_pc ? ex_pc : fwd_a;
    assign op_b = ex_src_b_imm ? ex_imm : fwd_b;

    always_comb begin
        case (ex_alu_op)
            rv_core_pkg::ALU_SUB:    alu_result = op_a - op_b;
            rv_core_pkg::ALU_SLL:    alu_result = op_a << op_b[4:0];
            rv_core_pkg::ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
            rv_core_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            rv_core_pkg::ALU_SRL:    alu_result = op_a >> op_b[4:0];
            rv_core_pkg::ALU_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
            rv_core_pkg::ALU_OR:     alu_result = op_a | op_b;
            rv_core_pkg::ALU_AND:    alu_result = op_a & op_b;
            rv_core_pkg::ALU_PASS_B: alu_result = op_b;
            rv_core_pkg::ALU_LINK:   alu_result = op_a + `RV_PC_STEP;
            default:                 alu_result = op_a + op_b;
        endcase
    end

    // Branches compare the forwarded registers, not the ALU operands
    always_comb begin
        case (ex_br_cond)
            rv_core_pkg::BR_EQ:  taken = fwd_a == fwd_b;
            rv_core_pkg::BR_NE:  taken = fwd_a != fwd_b;
            rv_core_pkg::BR_LT:  taken = $signed(fwd_a) < $signed(fwd_b);
            rv_core_pkg::BR_GE:  taken = $signed(fwd_a) >= $signed(fwd_b);
            rv_core_pkg::BR_LTU: taken = fwd_a < fwd_b;
            rv_core_pkg::BR_GEU: taken = fwd_a >= fwd_b;
            default:             taken = 1'b0;
        endcase
    end

    assign target      = (ex_jalr ? fwd_a : ex_pc) + ex_imm;
    assign redirect    = ex_jal || ex_jalr || taken;
    assign redirect_pc = {target[`RV_XLEN-1:1], target[0] && !ex_jalr};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            mem_reg_write <= 1'b0;
        end else begin
            mem_read      <= ex_mem_read;
            mem_write     <= ex_mem_write;
            mem_reg_write <= ex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr       <= alu_result;
        mem_store_data <= fwd_b;
        mem_width      <= ex_width;
        mem_rd         <= ex_rd;
    end

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    input  logic                      wb_en,
    input  logic [`RV_REG_ADDR_W-1:0] wb_rd,
    input  logic [`RV_XLEN-1:0]       wb_data,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rs1_data = (wb_en && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (wb_en && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule

`default_nettype wire

/* rtl/rv_result.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_result (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`RV_XLEN-1:0]         mem_addr,
    input  logic [`RV_XLEN-1:0]         mem_store_data,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  rv_core_pkg::mem_width_t     mem_width,
    input  logic [`RV_REG_ADDR_W-1:0]   mem_rd,
    input  logic                        mem_reg_write,
    input  logic [`RV_XLEN-1:0]         dm_out,
    output logic                        dm_read,
    output logic [3:0]                  dm_wen,
    output logic [`RV_XLEN-1:0]         dm_addr,
    output logic [`RV_XLEN-1:0]         dm_in,
    output logic                        wb_en,
    output logic [`RV_REG_ADDR_W-1:0]   wb_rd,
    output logic [`RV_XLEN-1:0]         wb_data
);

    logic [1:0]               lane;
    logic                     wb_load;
    rv_core_pkg::mem_width_t  wb_width;
    logic [`RV_XLEN-1:0]      wb_alu;
    logic [`RV_XLEN-1:0]      wb_word;
    logic [`RV_XLEN-1:0]      lane_word;
    logic [`RV_XLEN-1:0]      load_val;

    assign lane    = mem_addr[1:0];
    assign dm_read = mem_read;
    assign dm_addr = mem_addr;

    always_comb begin
        dm_wen = `RV_WEN_NONE;
        if (mem_write) begin
            case (mem_width)
                rv_core_pkg::MW_BYTE, rv_core_pkg::MW_UBYTE: begin
                    dm_wen = ~(4'b0001 << lane);
                end
                rv_core_pkg::MW_HALF, rv_core_pkg::MW_UHALF: begin
                    // Half-word crossing the word boundary is dropped
                    if (lane != 2'd3) begin
                        dm_wen = ~(4'b0011 << lane);
                    end
                end
                default: dm_wen = 4'b0000;
            endcase
        end
    end

    // Move the store data into its byte lanes
    always_comb begin
        case (mem_width)
            rv_core_pkg::MW_BYTE, rv_core_pkg::MW_UBYTE:
                dm_in = {24'b0, mem_store_data[7:0]} << {lane, 3'b000};
            rv_core_pkg::MW_HALF, rv_core_pkg::MW_UHALF:
                dm_in = {16'b0, mem_store_data[15:0]} << {lane, 3'b000};
            default:
                dm_in = mem_store_data;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en   <= 1'b0;
            wb_load <= 1'b0;
        end else begin
            wb_en   <= mem_reg_write;
            wb_load <= mem_read;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= mem_rd;
        wb_width <= mem_width;
        wb_alu   <= mem_addr;
        wb_word  <= dm_out;
    end

    assign lane_word = wb_word >> {wb_alu[1:0], 3'b000};

    always_comb begin
        case (wb_width)
            rv_core_pkg::MW_BYTE:  load_val = {{24{lane_word[7]}}, lane_word[7:0]};
            rv_core_pkg::MW_UBYTE: load_val = {24'b0, lane_word[7:0]};
            rv_core_pkg::MW_HALF:  load_val = {{16{lane_word[15]}}, lane_word[15:0]};
            rv_core_pkg::MW_UHALF: load_val = {16'b0, lane_word[15:0]};
            default:               load_val = wb_word;
        endcase
    end

    assign wb_data = wb_load ? load_val : wb_alu;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module rv_core_tb -f rv_core.f -o rv_core_sim

./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
grep -qF "*** TEST PASSED ***" sim.log

/* rv_core.f */
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_core.sv
verif/rv_core_tb.sv

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam logic [31:0] SEED      = 32'h2f9f_d33b;
    localparam logic [31:0] DATA_BASE = 32'h0000_0400;
    localparam logic [11:0] POISON_OFF = 12'h3f0;
    localparam logic [11:0] DONE_OFF   = 12'h3f8;
    localparam logic [11:0] BYTE_OFF   = 12'h200;
    localparam logic [11:0] HALF_OFF   = 12'h204;
    localparam int          TIMEOUT    = 4000;

    logic        clk;
    logic        rst;
    logic [31:0] im_addr;
    logic [31:0] im_out;
    logic        dm_read;
    logic [3:0]  dm_wen;
    logic [31:0] dm_addr;
    logic [31:0] dm_in;
    logic [31:0] dm_out;

    logic [31:0] imem [256];
    logic [31:0] dmem [512];
    logic [31:0] exp_addr [$];
    logic [3:0]  exp_wen [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_load [$];
    int          pc_idx;
    int          next_off;
    logic        done_seen;

    rv_core u_dut (
        .clk, .rst, .im_addr, .im_out, .dm_read, .dm_wen, .dm_addr, .dm_in, .dm_out
    );

    always #2 clk = ~clk;

    assign im_out = imem[im_addr[9:2]];
    assign dm_out = dmem[dm_addr[10:2]];

    always @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            if (!dm_wen[k]) begin
                dmem[dm_addr[10:2]][8*k +: 8] <= dm_in[8*k +: 8];
            end
        end
    end

    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_with(input string msg);
        $display("%s", msg);
        fail_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("ERROR %s got %h expected %h", name, got, want);
        fail_run();
    endtask

    // Instruction formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] alu_model(input logic alt, input logic [2:0] f3,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, sa < sb};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'(sa >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[pc_idx] = word;
        pc_idx++;
    endtask

    task automatic put_const(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] hi;
        hi = val + 32'h800;
        emit({hi[31:12], rd, 7'h37});
        emit(i_type(val[11:0], rd, 3'd0, rd, 7'h13));
    endtask

    task automatic store_expect(input logic [4:0] rs2, input logic [11:0] off,
                                input logic [3:0] wen, input logic [31:0] data,
                                input logic [2:0] f3);
        emit(s_type(off, rs2, 5'd10, f3));
        exp_addr.push_back(DATA_BASE + 32'(off));
        exp_wen.push_back(wen);
        exp_data.push_back(data);
    endtask

    task automatic load_expect(input logic [4:0] rd, input logic [11:0] off,
                               input logic [2:0] f3);
        emit(i_type(off, 5'd10, f3, rd, 7'h03));
        exp_load.push_back(DATA_BASE + 32'(off));
    endtask

    task automatic store_result(input logic [4:0] rd, input logic [31:0] value);
        store_expect(rd, 12'(next_off), 4'b0000, value, 3'b010);
        next_off += 4;
    endtask

    task automatic build_program();
        logic [31:0] va, vb, acc, rb, c13, sub, lnk;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [2:0]  op_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        logic        op_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        logic [2:0]  br_f3 [6] = '{0, 1, 4, 5, 6, 7};
        logic [4:0]  r1, r2;
        logic [7:0]  bv;
        logic [15:0] hv;
        va = $urandom;
        vb = $urandom;
        if (vb == va) vb = ~va;
        sh = 5'($urandom);
        imm = 12'($urandom);
        c13 = $urandom;
        sub = $urandom;
        emit(i_type(12'h400, 5'd0, 3'd0, 5'd10, 7'h13));
        put_const(1, va);
        put_const(2, vb);
        emit(i_type({7'b0, sh}, 5'd0, 3'd0, 5'd3, 7'h13));
        put_const(11, 32'hbad0_0bad);
        put_const(13, c13);
        // Dependent chain through x4
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd4));
        acc = va + vb;
        store_result(4, acc);
        for (int i = 0; i < 10; i++) begin
            rb = (op_f3[i] == 3'd1 || op_f3[i] == 3'd5) ? {27'b0, sh} : vb;
            r2 = (op_f3[i] == 3'd1 || op_f3[i] == 3'd5) ? 5'd3 : 5'd2;
            emit(r_type({1'b0, op_alt[i], 5'b0}, r2, 5'd4, op_f3[i], 5'd4));
            acc = alu_model(op_alt[i], op_f3[i], acc, rb);
            store_result(4, acc);
        end
        emit(r_type(7'h00, 5'd4, 5'd1, 3'd0, 5'd5));
        emit(r_type(7'h00, 5'd2, 5'd5, 3'd4, 5'd5));
        store_result(5, (va + acc) ^ vb);
        emit(i_type(imm, 5'd1, 3'd0, 5'd6, 7'h13));
        store_result(6, va + {{20{imm[11]}}, imm});
        emit(i_type(imm, 5'd2, 3'd2, 5'd7, 7'h13));
        store_result(7, alu_model(1'b0, 3'd2, vb, {{20{imm[11]}}, imm}));
        emit(i_type({7'h20, sh}, 5'd1, 3'd5, 5'd8, 7'h13));
        store_result(8, alu_model(1'b1, 3'd5, va, {27'b0, sh}));
        emit({va[31:12], 5'd17, 7'h37});
        store_result(17, {va[31:12], 12'b0});
        lnk = 32'(pc_idx * 4);
        emit({vb[31:12], 5'd18, 7'h17});
        store_result(18, lnk + {vb[31:12], 12'b0});
        // Load-use on the first stored word
        load_expect(6, 12'h000, 3'b010);
        emit(r_type(7'h00, 5'd1, 5'd6, 3'd0, 5'd7));
        store_result(7, va + vb + va);
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 3; p++) begin
                r1 = (p == 1) ? 5'd2 : 5'd1;
                r2 = (p == 0) ? 5'd2 : 5'd1;
                emit(b_type(13'd8, r2, r1, br_f3[i]));
                if (branch_model(br_f3[i], r1 == 5'd1 ? va : vb, r2 == 5'd1 ? va : vb)) begin
                    emit(s_type(POISON_OFF, 5'd11, 5'd10, 3'b010));
                end else begin
                    store_result(13, c13);
                end
            end
        end
        lnk = 32'(pc_idx * 4);
        emit(j_type(21'd8, 5'd14));
        emit(s_type(POISON_OFF, 5'd11, 5'd10, 3'b010));
        store_result(14, lnk + 32'd4);
        lnk = 32'(pc_idx * 4);
        emit(i_type(12'(lnk + 32'd8), 5'd0, 3'd0, 5'd16, 7'h67));
        emit(s_type(POISON_OFF, 5'd11, 5'd10, 3'b010));
        store_result(16, lnk + 32'd4);
        // Sub-word stores and their read-back, a different byte per lane
        put_const(20, sub);
        for (int k = 0; k < 4; k++) begin
            emit(i_type(12'(8 * k), 5'd20, 3'd5, 5'd23, 7'h13));
            store_expect(23, BYTE_OFF + 12'(k), ~(4'b0001 << k),
                         sub & (32'h0000_00ff << (8 * k)), 3'b000);
        end
        for (int k = 0; k < 4; k += 2) begin
            emit(i_type(12'(8 * k), 5'd20, 3'd5, 5'd23, 7'h13));
            store_expect(23, HALF_OFF + 12'(k), ~(4'b0011 << k),
                         sub & (32'h0000_ffff << (8 * k)), 3'b001);
        end
        for (int k = 0; k < 4; k++) begin
            bv = sub[8*k +: 8];
            load_expect(21, BYTE_OFF + 12'(k), 3'b000);
            store_result(21, {{24{bv[7]}}, bv});
            load_expect(21, BYTE_OFF + 12'(k), 3'b100);
            store_result(21, {24'b0, bv});
        end
        for (int k = 0; k < 4; k += 2) begin
            hv = sub[8*k +: 16];
            load_expect(21, HALF_OFF + 12'(k), 3'b001);
            store_result(21, {{16{hv[15]}}, hv});
            load_expect(21, HALF_OFF + 12'(k), 3'b101);
            store_result(21, {16'b0, hv});
        end
        put_const(22, 32'h600d_d0e5);
        store_expect(22, DONE_OFF, 4'b0000, 32'h600d_d0e5, 3'b010);
        emit(j_type(21'd0, 5'd0));
    endtask

    // Every store and load is compared with the next expected one
    always @(negedge clk) begin
        logic [31:0] mask;
        if (!rst && dm_wen != 4'b1111) begin
            assert (dm_addr != DATA_BASE + 32'(POISON_OFF))
            else fail_with("a store reached the poison address, a branch or jump went wrong");
            assert (exp_addr.size() != 0)
            else fail_with("store seen after all expected stores were done");
            mask = {{8{!exp_wen[0][3]}}, {8{!exp_wen[0][2]}}, {8{!exp_wen[0][1]}},
                    {8{!exp_wen[0][0]}}};
            assert (dm_addr == exp_addr[0]) else report_mismatch("dm_addr", dm_addr, exp_addr[0]);
            assert (dm_wen == exp_wen[0])
            else report_mismatch("dm_wen", {28'b0, dm_wen}, {28'b0, exp_wen[0]});
            assert ((dm_in & mask) == (exp_data[0] & mask))
            else report_mismatch("dm_in", dm_in & mask, exp_data[0] & mask);
            if (dm_addr == DATA_BASE + 32'(DONE_OFF)) done_seen = 1'b1;
            void'(exp_addr.pop_front());
            void'(exp_wen.pop_front());
            void'(exp_data.pop_front());
        end
        if (!rst && dm_read) begin
            assert (exp_load.size() != 0)
            else fail_with("load seen after all expected loads were done");
            assert (dm_addr == exp_load[0])
            else report_mismatch("dm_addr", dm_addr, exp_load[0]);
            void'(exp_load.pop_front());
        end
    end

    initial begin
        int cycles;
        void'($urandom(SEED));
        clk = 1'b0;
        rst = 1'b1;
        done_seen = 1'b0;
        pc_idx = 0;
        next_off = 0;
        for (int i = 0; i < 256; i++) imem[i] = {12'(i), 20'h00013};
        for (int i = 0; i < 512; i++) dmem[i] = {16'(i), ~16'(i)} ^ 32'h5a5a_0000;
        build_program();
        repeat (2) @(negedge clk);
        assert (im_addr == 32'h0) else report_mismatch("im_addr", im_addr, 32'h0);
        assert (dm_wen == 4'b1111) else report_mismatch("dm_wen", {28'b0, dm_wen}, 32'hf);
        assert (!dm_read) else report_mismatch("dm_read", {31'b0, dm_read}, 32'h0);
        rst = 1'b0;
        cycles = 0;
        while (!done_seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done_seen) begin
            fail_with("timeout waiting for the done store");
        end
        if (exp_addr.size() != 0 || exp_load.size() != 0) begin
            $display("%0d expected stores and %0d expected loads never happened",
                     exp_addr.size(), exp_load.size());
            fail_run();
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
